/* bench/tb_pooling_controller.sv */
/*
 * Testbench for the average pooling engine
 * Register access, blocked stream and three checked frames with the last under back-pressure
 */
`timescale 1ns/1ps
`include "pool_defs.svh"
`default_nettype none

module tb_pooling_controller
    import pool_pkg::*;
();

    localparam int K = `KERNEL_SIZE;
    localparam int C = `CHANNELS;
    localparam int IMG_W = 6;
    localparam int IMG_H = 5;
    // Whole run is near 1500 cycles so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic                       axi_clk, axi_reset_n;
    logic [`AXI_ADDR_WIDTH-1:0] s_axi_awaddr, s_axi_araddr;
    logic                       s_axi_awvalid, s_axi_awready;
    logic [`BUS_WIDTH-1:0]      s_axi_wdata, s_axi_rdata;
    logic                       s_axi_wvalid, s_axi_wready;
    logic                       s_axi_bvalid, s_axi_bready;
    logic                       s_axi_arvalid, s_axi_arready;
    logic                       s_axi_rvalid, s_axi_rready;
    logic                       s_axis_valid, s_axis_ready, s_axis_last;
    pixel_t                     s_axis_data, m_axis_data;
    logic                       m_axis_valid, m_axis_ready, m_axis_last;

    pixel_t frames [2][C][IMG_H][IMG_W];    // Frame, channel, row, column
    pixel_t exp_data [$];                   // Reference words in output order
    logic   exp_last [$];
    pixel_t exp_word;
    logic   exp_lst;
    int     words_seen = 0;
    int     cycle_count = 0;
    logic   start_on = 1'b0;                // Start bit as last written
    logic   stall_out = 1'b0;               // Random holds on m_axis_ready

    pooling_controller u_pooling_controller (.*);   // Port names match one to one

    // --------------------
    // Failure reporting
    // --------------------
    task automatic fail_run();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic show_mismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        fail_run();
    endtask

    task automatic show_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        fail_run();
    endtask

    initial begin
        axi_clk = 1'b0;
        forever #10 axi_clk = ~axi_clk;     // 20 ns period
    end

    always @(posedge axi_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            show_error("the run did not finish within the cycle limit");
    end

    // Sink ready low about one cycle in three when stalling
    always @(negedge axi_clk) begin
        if (stall_out)
            m_axis_ready = ($urandom_range(0, 2) != 0);
        else
            m_axis_ready = 1'b1;
    end

    // --------------------
    // Checks
    // --------------------
    a_hold: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
        m_axis_valid && !m_axis_ready |=>
            m_axis_valid && $stable(m_axis_data) && $stable(m_axis_last))
        else show_mismatch("output word changed while stalled");

    a_idle: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
        !start_on |-> !s_axis_ready && !m_axis_valid)
        else show_mismatch("stream moved while start was low");

    a_last: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
        m_axis_last |-> m_axis_valid)
        else show_mismatch("last flag without a valid word");

    // Each accepted word against the head of the reference queue
    always @(posedge axi_clk) begin
        if (axi_reset_n && m_axis_valid && m_axis_ready) begin
            if (exp_data.size() == 0) begin
                show_error("an output word arrived with nothing left to expect");
            end else begin
                exp_word = exp_data.pop_front();
                exp_lst  = exp_last.pop_front();
                assert (m_axis_data == exp_word)
                    else show_mismatch($sformatf("word %0d is %h, expected %h",
                                                 words_seen, m_axis_data, exp_word));
                assert (m_axis_last == exp_lst)
                    else show_mismatch($sformatf("word %0d last is %b, expected %b",
                                                 words_seen, m_axis_last, exp_lst));
                words_seen = words_seen + 1;
            end
        end
    end

    // --------------------
    // Register access
    // --------------------
    task automatic write_reg(input logic [`AXI_ADDR_WIDTH-1:0] addr,
                             input logic [`BUS_WIDTH-1:0] data);
        logic aw_done, w_done;
        aw_done       = 1'b0;
        w_done        = 1'b0;
        s_axi_awaddr  = addr;
        s_axi_awvalid = 1'b1;
        s_axi_wdata   = data;
        s_axi_wvalid  = 1'b1;
        s_axi_bready  = 1'b1;
        while (!(aw_done && w_done)) begin
            @(posedge axi_clk);
            assert (!s_axi_bvalid) else show_mismatch("bvalid high before the write was taken");
            if (s_axi_awvalid && s_axi_awready)
                aw_done = 1'b1;
            if (s_axi_wvalid && s_axi_wready)
                w_done = 1'b1;
            @(negedge axi_clk);
            if (aw_done)
                s_axi_awvalid = 1'b0;
            if (w_done)
                s_axi_wvalid = 1'b0;
        end
        @(posedge axi_clk);
        while (!s_axi_bvalid)               // Response handshake
            @(posedge axi_clk);
        @(negedge axi_clk);
        s_axi_bready = 1'b0;
    endtask

    task automatic read_reg(input logic [`AXI_ADDR_WIDTH-1:0] addr,
                            output logic [`BUS_WIDTH-1:0] data);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        s_axi_rready  = 1'b1;
        @(posedge axi_clk);
        while (!s_axi_arready)
            @(posedge axi_clk);
        assert (!s_axi_rvalid) else show_mismatch("rvalid high before the read was taken");
        @(negedge axi_clk);
        s_axi_arvalid = 1'b0;
        @(posedge axi_clk);
        while (!s_axi_rvalid)
            @(posedge axi_clk);
        data = s_axi_rdata;
        @(negedge axi_clk);
        s_axi_rready = 1'b0;
    endtask

    task automatic check_reg(input logic [`AXI_ADDR_WIDTH-1:0] addr,
                             input logic [`BUS_WIDTH-1:0] expected);
        logic [`BUS_WIDTH-1:0] value;
        read_reg(addr, value);
        assert (value == expected)
            else show_mismatch($sformatf("register %0d read %h, expected %h",
                                         addr, value, expected));
    endtask

    // --------------------
    // Frames and reference model
    // --------------------
    task automatic fill_frame(input int f);
        for (int c = 0; c < C; c++)
            for (int y = 0; y < IMG_H; y++)
                for (int x = 0; x < IMG_W; x++)
                    frames[f][c][y][x] = $urandom();   // Full range to load the sums
    endtask

    // Floor of the K x K sum over K*K in raster order then channel
    task automatic queue_expected(input int f);
        longint unsigned sum;
        for (int y = 0; y <= IMG_H - K; y++)
            for (int x = 0; x <= IMG_W - K; x++)
                for (int c = 0; c < C; c++) begin
                    sum = 0;
                    for (int r = 0; r < K; r++)
                        for (int k = 0; k < K; k++)
                            sum += 64'(frames[f][c][y+r][x+k]);
                    exp_data.push_back(pixel_t'(sum / 64'(K * K)));
                    exp_last.push_back(y == IMG_H - K && x == IMG_W - K && c == C - 1);
                end
    endtask

    // Beats go out row by row with channels interleaved within a column
    task automatic stream_frame(input int f, input bit gaps);
        for (int y = 0; y < IMG_H; y++)
            for (int x = 0; x < IMG_W; x++)
                for (int c = 0; c < C; c++) begin
                    if (gaps)
                        while ($urandom_range(0, 3) == 0)
                            @(negedge axi_clk);     // Idle cycle with valid low
                    s_axis_valid = 1'b1;
                    s_axis_data  = frames[f][c][y][x];
                    @(posedge axi_clk);
                    while (!s_axis_ready)
                        @(posedge axi_clk);
                    @(negedge axi_clk);
                    s_axis_valid = 1'b0;
                end
    endtask

    task automatic finish_frame();
        while (exp_data.size() != 0)
            @(negedge axi_clk);
        // An extra word before the engine asks for rows again lands on an empty queue
        while (!s_axis_ready)
            @(negedge axi_clk);
        words_seen = 0;
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        void'($urandom(32'hb38b));
        axi_reset_n   = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        s_axis_valid  = 1'b0;
        s_axis_data   = '0;
        s_axis_last   = 1'b0;       // Ignored by the DUT
        m_axis_ready  = 1'b1;
        repeat (5) @(posedge axi_clk);
        @(negedge axi_clk);
        axi_reset_n = 1'b1;
        assert (!s_axis_ready && !m_axis_valid && !m_axis_last && !s_axi_bvalid
                && !s_axi_rvalid && s_axi_awready && s_axi_arready)
            else show_mismatch("outputs not at their reset values");

        // Offered pixels must not be taken while start is low
        s_axis_valid = 1'b1;
        s_axis_data  = 32'h1234_5678;
        repeat (50) begin
            @(posedge axi_clk);
            assert (!s_axis_ready && !m_axis_valid)
                else show_mismatch("stream active with start low");
        end
        @(negedge axi_clk);
        s_axis_valid = 1'b0;

        // Readback with start bit 0 left low so the engine stays idle
        write_reg(`REG_WIDTH, IMG_W);
        write_reg(`REG_HEIGHT, IMG_H);
        write_reg(`REG_START, 32'h2);
        check_reg(`REG_WIDTH, IMG_W);
        check_reg(`REG_HEIGHT, IMG_H);
        check_reg(`REG_START, 32'h2);

        write_reg(`REG_CLEAR, 32'h1);
        check_reg(`REG_WIDTH, 0);
        check_reg(`REG_HEIGHT, 0);
        check_reg(`REG_START, 0);
        check_reg(`REG_CLEAR, 0);

        write_reg(`REG_WIDTH, IMG_W);
        write_reg(`REG_HEIGHT, IMG_H);
        write_reg(`REG_START, 32'h1);
        start_on = 1'b1;

        fill_frame(0);
        queue_expected(0);
        stream_frame(0, 1'b0);
        finish_frame();

        fill_frame(1);              // Second frame with start still high
        queue_expected(1);
        stream_frame(1, 1'b0);
        finish_frame();

        stall_out = 1'b1;           // First frame again under gaps and stalls
        queue_expected(0);
        stream_frame(0, 1'b1);
        finish_frame();
        stall_out = 1'b0;

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+src
src/pool_pkg.sv
src/pool_ctrl_regs.sv
src/pixel_deinterleave.sv
src/line_buffer.sv
src/window_pool.sv
src/pooling_controller.sv
bench/tb_pooling_controller.sv

/* run.sh */
#!/bin/sh
# Build and run the pooling engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module tb_pooling_controller \
    -Mdir obj_dir -o sim_pooling

./obj_dir/sim_pooling

/* src/line_buffer.sv */
/*
 * Line buffer for one channel
 * K circular row slots with a registered one-column read, oldest row first
 */
`timescale 1ns/1ps
`include "pool_defs.svh"
`default_nettype none

module line_buffer
    import pool_pkg::*;
(
    input  wire                         axi_clk,
    input  wire                         wr_en,
    input  wire slot_idx_t              wr_slot,
    input  wire col_idx_t               wr_col,
    input  wire pixel_t                 wr_data,
    input  wire                         rd_en,
    input  wire col_idx_t               rd_col,
    input  wire slot_idx_t              oldest_slot,
    output pixel_t [`KERNEL_SIZE-1:0]   rd_data         // Index 0 is the oldest row
);

    pixel_t    mem [`KERNEL_SIZE][`MAX_ROW_WIDTH];
    slot_idx_t rd_slot [`KERNEL_SIZE];      // Physical slot behind each window row

    // Rotate from the oldest slot around the ring
    always_comb begin
        for (int k = 0; k < `KERNEL_SIZE; k++) begin
            if (int'(oldest_slot) + k >= `KERNEL_SIZE)
                rd_slot[k] = slot_idx_t'(int'(oldest_slot) + k - `KERNEL_SIZE);
            else
                rd_slot[k] = slot_idx_t'(int'(oldest_slot) + k);
        end
    end

    always_ff @(posedge axi_clk) begin
        if (wr_en)
            mem[wr_slot][wr_col] <= wr_data;
    end

    // Column out one cycle after rd_en
    always_ff @(posedge axi_clk) begin
        if (rd_en) begin
            for (int k = 0; k < `KERNEL_SIZE; k++)
                rd_data[k] <= mem[rd_slot[k]][rd_col];
        end
    end

endmodule

`default_nettype wire

/* src/pixel_deinterleave.sv */
/*
 * Pixel feeder
 * Splits the interleaved input stream into per-channel line buffer writes
 */
`timescale 1ns/1ps
`include "pool_defs.svh"
`default_nettype none

module pixel_deinterleave
    import pool_pkg::*;
(
    input  wire                     axi_clk,
    input  wire                     axi_reset_n,
    input  wire                     s_axis_valid,
    input  wire pixel_t             s_axis_data,
    output logic                    s_axis_ready,
    input  wire                     fill_en,        // Engine wants rows
    input  wire col_idx_t           image_width,
    input  wire                     frame_done,     // Restart at slot 0 and column 0
    output logic [`CHANNELS-1:0]    lb_wr_en,       // One hot over channels
    output slot_idx_t               lb_wr_slot,
    output col_idx_t                lb_wr_col,
    output pixel_t                  lb_wr_data,
    output logic                    row_done,
    output slot_idx_t               oldest_slot
);

    chan_idx_t chan;        // Channel of the next beat
    col_idx_t  col;         // Column of the next beat
    slot_idx_t slot;        // Slot being filled which is also the oldest row held
    logic      accept;
    logic      last_chan, last_col;

    assign s_axis_ready = fill_en;
    assign accept       = s_axis_valid && fill_en;
    assign last_chan    = chan == chan_idx_t'(`CHANNELS - 1);
    assign last_col     = col == image_width - 1'b1;

    // Steer the beat to its own channel
    always_comb begin
        lb_wr_en       = '0;
        lb_wr_en[chan] = accept;
    end

    assign lb_wr_slot  = slot;
    assign lb_wr_col   = col;
    assign lb_wr_data  = s_axis_data;
    assign row_done    = accept && last_chan && last_col;  // Same cycle as the final beat
    assign oldest_slot = slot;

    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n || frame_done) begin
            chan <= '0;
            col  <= '0;
            slot <= '0;
        end else if (accept) begin
            if (!last_chan) begin
                chan <= chan + 1'b1;
            end else begin
                chan <= '0;
                if (!last_col) begin
                    col <= col + 1'b1;
                end else begin
                    col  <= '0;
                    // Next row overwrites the oldest one
                    slot <= (slot == slot_idx_t'(`KERNEL_SIZE - 1)) ? '0 : slot + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/pool_ctrl_regs.sv */
/*
 * AXI-lite register block
 * Holds start, clear, width and height and serves one transfer at a time
 */
`timescale 1ns/1ps
`include "pool_defs.svh"
`default_nettype none

module pool_ctrl_regs
    import pool_pkg::*;
(
    input  wire                         axi_clk,
    input  wire                         axi_reset_n,
    // Write address, data and response
    input  wire [`AXI_ADDR_WIDTH-1:0]   s_axi_awaddr,
    input  wire                         s_axi_awvalid,
    output logic                        s_axi_awready,
    input  wire [`BUS_WIDTH-1:0]        s_axi_wdata,
    input  wire                         s_axi_wvalid,
    output logic                        s_axi_wready,
    output logic                        s_axi_bvalid,
    input  wire                         s_axi_bready,
    // Read address and data
    input  wire [`AXI_ADDR_WIDTH-1:0]   s_axi_araddr,
    input  wire                         s_axi_arvalid,
    output logic                        s_axi_arready,
    output logic [`BUS_WIDTH-1:0]       s_axi_rdata,
    output logic                        s_axi_rvalid,
    input  wire                         s_axi_rready,
    // Levels to the datapath
    output logic                        start,
    output col_idx_t                    image_width,
    output col_idx_t                    image_height
);

    // --------------------
    // Register file
    // --------------------
    logic [`BUS_WIDTH-1:0]      start_reg, clear_reg, width_reg, height_reg;

    logic                       aw_seen, w_seen;    // Halves of a pending write
    logic [`AXI_ADDR_WIDTH-1:0] wr_addr;
    logic [`BUS_WIDTH-1:0]      wr_data;
    logic                       aw_hs, w_hs, ar_hs;

    // Each write half is taken once, nothing new while a response is out
    assign s_axi_awready = !aw_seen && !s_axi_bvalid && !s_axi_rvalid;
    assign s_axi_wready  = !w_seen && !s_axi_bvalid && !s_axi_rvalid;
    // Reads only on a quiet port and writes win a tie
    assign s_axi_arready = !aw_seen && !w_seen && !s_axi_bvalid && !s_axi_rvalid
                           && !s_axi_awvalid && !s_axi_wvalid;

    assign aw_hs = s_axi_awvalid && s_axi_awready;
    assign w_hs  = s_axi_wvalid && s_axi_wready;
    assign ar_hs = s_axi_arvalid && s_axi_arready;

    // Captured address, data and read word
    always_ff @(posedge axi_clk) begin
        if (aw_hs)
            wr_addr <= s_axi_awaddr;
        if (w_hs)
            wr_data <= s_axi_wdata;
        if (ar_hs) begin
            case (s_axi_araddr)
                `REG_START:  s_axi_rdata <= start_reg;
                `REG_CLEAR:  s_axi_rdata <= clear_reg;
                `REG_WIDTH:  s_axi_rdata <= width_reg;
                `REG_HEIGHT: s_axi_rdata <= height_reg;
                default:     s_axi_rdata <= '0;     // Unmapped reads as zero
            endcase
        end
    end

    // --------------------
    // Transfer control
    // --------------------
    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n) begin
            aw_seen      <= 1'b0;
            w_seen       <= 1'b0;
            s_axi_bvalid <= 1'b0;
            s_axi_rvalid <= 1'b0;
            start_reg    <= '0;
            clear_reg    <= '0;
            width_reg    <= '0;
            height_reg   <= '0;
        end else begin
            if (aw_hs)
                aw_seen <= 1'b1;
            if (w_hs)
                w_seen <= 1'b1;
            if (aw_seen && w_seen) begin        // Both halves in, commit and respond
                aw_seen      <= 1'b0;
                w_seen       <= 1'b0;
                s_axi_bvalid <= 1'b1;
                case (wr_addr)
                    `REG_START:  start_reg  <= wr_data;
                    `REG_CLEAR:  clear_reg  <= wr_data;
                    `REG_WIDTH:  width_reg  <= wr_data;
                    `REG_HEIGHT: height_reg <= wr_data;
                    default: ;
                endcase
                // Clear bit overrides everything, itself included
                if (wr_addr == `REG_CLEAR && wr_data[0]) begin
                    start_reg  <= '0;
                    clear_reg  <= '0;
                    width_reg  <= '0;
                    height_reg <= '0;
                end
            end else if (s_axi_bvalid && s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
            if (ar_hs)
                s_axi_rvalid <= 1'b1;
            else if (s_axi_rvalid && s_axi_rready)
                s_axi_rvalid <= 1'b0;
        end
    end

    assign start        = start_reg[0];
    assign image_width  = col_idx_t'(width_reg);    // Upper bits beyond the buffer depth
    assign image_height = col_idx_t'(height_reg);

endmodule

`default_nettype wire

/* src/pool_defs.svh */
/*
 * Pooling engine constants
 * Window, channel and bus sizes and the register map
 */
`ifndef POOL_DEFS_SVH
`define POOL_DEFS_SVH
`default_nettype none

// --------------------
// Geometry
// --------------------
`define KERNEL_SIZE     3       // Square window side
`define CHANNELS        3       // Interleaved pixel channels
`define MAX_ROW_WIDTH   64      // Pixels per line buffer row

// Bus widths
`define BUS_WIDTH       32
`define AXI_ADDR_WIDTH  10

// --------------------
// Register map in byte addresses
// --------------------
`define REG_START       0       // Bit 0 enables processing
`define REG_CLEAR       4       // Bit 0 zeroes every register
`define REG_WIDTH       16      // Image width in pixels
`define REG_HEIGHT      20      // Image height in rows

`default_nettype wire
`endif

/* src/pool_pkg.sv */
/*
 * Pooling engine types shared by the register block, feeder and engine
 */
`include "pool_defs.svh"
`default_nettype none

package pool_pkg;

    typedef logic [`BUS_WIDTH-1:0] pixel_t;     // One pixel or one average

    // Room for K*K full scale pixels
    typedef logic [`BUS_WIDTH+$clog2(`KERNEL_SIZE*`KERNEL_SIZE)-1:0] pool_sum_t;

    typedef logic [$clog2(`MAX_ROW_WIDTH)-1:0] col_idx_t;    // Column within a row
    typedef logic [$clog2(`KERNEL_SIZE)-1:0]   slot_idx_t;   // Line buffer row slot
    typedef logic [$clog2(`CHANNELS)-1:0]      chan_idx_t;   // Channel number

    // Pooling engine FSM
    typedef enum logic [2:0] {
        ST_IDLE,        // Waiting for start
        ST_FILL,        // Feeder writing rows
        ST_READ,        // Column reads toward a window
        ST_SUM,         // Averages being formed
        ST_SERVE        // Averages going out
    } pool_state_t;

endpackage

`default_nettype wire

/* src/pooling_controller.sv */
/*
 * Average pooling top level
 * Register block, pixel feeder, per-channel line buffers and pooling engine
 */
`timescale 1ns/1ps
`include "pool_defs.svh"
`default_nettype none

module pooling_controller
    import pool_pkg::*;
(
    input  wire                         axi_clk,
    input  wire                         axi_reset_n,
    // AXI-lite register port
    input  wire [`AXI_ADDR_WIDTH-1:0]   s_axi_awaddr,
    input  wire                         s_axi_awvalid,
    output logic                        s_axi_awready,
    input  wire [`BUS_WIDTH-1:0]        s_axi_wdata,
    input  wire                         s_axi_wvalid,
    output logic                        s_axi_wready,
    output logic                        s_axi_bvalid,
    input  wire                         s_axi_bready,
    input  wire [`AXI_ADDR_WIDTH-1:0]   s_axi_araddr,
    input  wire                         s_axi_arvalid,
    output logic                        s_axi_arready,
    output logic [`BUS_WIDTH-1:0]       s_axi_rdata,
    output logic                        s_axi_rvalid,
    input  wire                         s_axi_rready,
    // Pixel stream in
    input  wire                         s_axis_valid,
    input  wire pixel_t                 s_axis_data,
    output logic                        s_axis_ready,
    input  wire                         s_axis_last,    // Frame size comes from the registers
    // Averages out
    output logic                        m_axis_valid,
    output pixel_t                      m_axis_data,
    input  wire                         m_axis_ready,
    output logic                        m_axis_last
);

    logic                  start;
    col_idx_t              image_width, image_height;
    logic                  fill_en, row_done, frame_done;
    logic [`CHANNELS-1:0]  lb_wr_en;
    slot_idx_t             lb_wr_slot, oldest_slot;
    col_idx_t              lb_wr_col, rd_col;
    pixel_t                lb_wr_data;
    logic                  rd_en;
    pixel_t [`CHANNELS-1:0][`KERNEL_SIZE-1:0] lb_rd_data;   // One column per channel

    pool_ctrl_regs u_pool_ctrl_regs (
        .axi_clk       (axi_clk),
        .axi_reset_n   (axi_reset_n),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .start         (start),
        .image_width   (image_width),
        .image_height  (image_height)
    );

    pixel_deinterleave u_pixel_deinterleave (
        .axi_clk      (axi_clk),
        .axi_reset_n  (axi_reset_n),
        .s_axis_valid (s_axis_valid),
        .s_axis_data  (s_axis_data),
        .s_axis_ready (s_axis_ready),
        .fill_en      (fill_en),
        .image_width  (image_width),
        .frame_done   (frame_done),
        .lb_wr_en     (lb_wr_en),
        .lb_wr_slot   (lb_wr_slot),
        .lb_wr_col    (lb_wr_col),
        .lb_wr_data   (lb_wr_data),
        .row_done     (row_done),
        .oldest_slot  (oldest_slot)
    );

    // One line buffer per channel sharing the read column
    for (genvar g = 0; g < `CHANNELS; g++) begin : g_lb
        line_buffer u_line_buffer (
            .axi_clk     (axi_clk),
            .wr_en       (lb_wr_en[g]),
            .wr_slot     (lb_wr_slot),
            .wr_col      (lb_wr_col),
            .wr_data     (lb_wr_data),
            .rd_en       (rd_en),
            .rd_col      (rd_col),
            .oldest_slot (oldest_slot),
            .rd_data     (lb_rd_data[g])
        );
    end

    window_pool u_window_pool (
        .axi_clk      (axi_clk),
        .axi_reset_n  (axi_reset_n),
        .start        (start),
        .image_width  (image_width),
        .image_height (image_height),
        .fill_en      (fill_en),
        .row_done     (row_done),
        .rd_en        (rd_en),
        .rd_col       (rd_col),
        .lb_rd_data   (lb_rd_data),
        .frame_done   (frame_done),
        .m_axis_valid (m_axis_valid),
        .m_axis_data  (m_axis_data),
        .m_axis_ready (m_axis_ready),
        .m_axis_last  (m_axis_last)
    );

endmodule

`default_nettype wire

/* src/window_pool.sv */
/*
 * Pooling engine
 * Builds K x K windows from the line buffers and streams one average per channel
 */
`timescale 1ns/1ps
`include "pool_defs.svh"
`default_nettype none

module window_pool
    import pool_pkg::*;
(
    input  wire                     axi_clk,
    input  wire                     axi_reset_n,
    input  wire                     start,
    input  wire col_idx_t           image_width,
    input  wire col_idx_t           image_height,
    output logic                    fill_en,
    input  wire                     row_done,
    output logic                    rd_en,
    output col_idx_t                rd_col,
    input  wire pixel_t [`CHANNELS-1:0][`KERNEL_SIZE-1:0] lb_rd_data,
    output logic                    frame_done,
    output logic                    m_axis_valid,
    output pixel_t                  m_axis_data,
    input  wire                     m_axis_ready,
    output logic                    m_axis_last
);

    typedef logic [$clog2(`KERNEL_SIZE+1)-1:0] k_cnt_t;    // Counts 0 to K

    pool_state_t state;
    col_idx_t    win_x, win_y;      // Top left corner of the window
    col_idx_t    rd_ptr;            // Next column to read
    k_cnt_t      rows_left;         // row_done pulses still owed
    k_cnt_t      reads_left;        // Column reads still to issue
    logic        rd_valid;          // Column data present on lb_rd_data
    chan_idx_t   out_chan;
    logic        out_hs, row_end, frame_end;

    pixel_t      win      [`CHANNELS][`KERNEL_SIZE][`KERNEL_SIZE];   // Chan, row, col
    pixel_t      win_next [`CHANNELS][`KERNEL_SIZE][`KERNEL_SIZE];
    pool_sum_t   win_sum  [`CHANNELS];
    pixel_t      avg      [`CHANNELS];

    assign fill_en      = state == ST_FILL;
    assign rd_en        = state == ST_READ;
    assign rd_col       = rd_ptr;
    assign m_axis_valid = state == ST_SERVE;
    assign m_axis_data  = avg[out_chan];            // Held until the handshake
    assign row_end      = win_x == image_width - col_idx_t'(`KERNEL_SIZE);
    assign frame_end    = row_end && win_y == image_height - col_idx_t'(`KERNEL_SIZE);
    assign m_axis_last  = m_axis_valid && frame_end && out_chan == chan_idx_t'(`CHANNELS - 1);
    assign out_hs       = m_axis_valid && m_axis_ready;
    assign frame_done   = out_hs && m_axis_last;

    // --------------------
    // Window shift and sums
    // --------------------
    always_comb begin
        for (int c = 0; c < `CHANNELS; c++) begin
            win_sum[c] = '0;
            for (int r = 0; r < `KERNEL_SIZE; r++) begin
                for (int x = 0; x < `KERNEL_SIZE - 1; x++)
                    win_next[c][r][x] = win[c][r][x+1];         // Slide left
                win_next[c][r][`KERNEL_SIZE-1] = lb_rd_data[c][r];  // New column on the right
                for (int x = 0; x < `KERNEL_SIZE; x++)
                    win_sum[c] = win_sum[c] + pool_sum_t'(win_next[c][r][x]);
            end
        end
    end

    always_ff @(posedge axi_clk) begin
        if (rd_valid)
            win <= win_next;
        // Last column arrives during SUM so the average uses win_next
        if (state == ST_SUM) begin
            for (int c = 0; c < `CHANNELS; c++)
                avg[c] <= pixel_t'(win_sum[c] / (`KERNEL_SIZE * `KERNEL_SIZE));
        end
    end

    // --------------------
    // Position and output FSM
    // --------------------
    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n) begin
            state      <= ST_IDLE;
            win_x      <= '0;
            win_y      <= '0;
            rd_ptr     <= '0;
            rows_left  <= '0;
            reads_left <= '0;
            rd_valid   <= 1'b0;
            out_chan   <= '0;
        end else begin
            rd_valid <= rd_en;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state     <= ST_FILL;
                        rows_left <= k_cnt_t'(`KERNEL_SIZE);   // Full window of rows first
                    end
                end
                ST_FILL: begin
                    if (row_done) begin
                        rows_left <= rows_left - 1'b1;
                        if (rows_left == k_cnt_t'(1)) begin
                            state      <= ST_READ;
                            reads_left <= k_cnt_t'(`KERNEL_SIZE);
                        end
                    end
                end
                ST_READ: begin
                    rd_ptr     <= rd_ptr + 1'b1;
                    reads_left <= reads_left - 1'b1;
                    if (reads_left == k_cnt_t'(1))
                        state <= ST_SUM;
                end
                ST_SUM: begin
                    state    <= ST_SERVE;
                    out_chan <= '0;
                end
                ST_SERVE: begin
                    if (out_hs) begin
                        if (out_chan != chan_idx_t'(`CHANNELS - 1)) begin
                            out_chan <= out_chan + 1'b1;
                        end else if (frame_end) begin
                            win_x  <= '0;
                            win_y  <= '0;
                            rd_ptr <= '0;
                            state  <= ST_IDLE;
                        end else if (row_end) begin
                            win_x     <= '0;
                            win_y     <= win_y + 1'b1;
                            rd_ptr    <= '0;
                            rows_left <= k_cnt_t'(1);       // One fresh row per step down
                            state     <= ST_FILL;
                        end else begin
                            win_x      <= win_x + 1'b1;
                            reads_left <= k_cnt_t'(1);      // Only the new right column
                            state      <= ST_READ;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire
